// File: include/rv_defines.svh
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// Width of integer registers and ALU datapath
`define RV_XLEN 32

// Architectural register count including x0
`define RV_REG_COUNT 32

// Bits needed to index one register
`define RV_REG_ADDR_BITS 5

// Canonical NOP encoded as ADDI on x0 with zero immediate
`define RV_NOP_INST 32'h0000_0013

`endif

// File: hdl/RvIsa.sv
`include "rv_defines.svh"

package RvIsa;

    typedef logic [31:0]                  Inst;      // Raw instruction word
    typedef logic [`RV_XLEN-1:0]          Data;      // Operand or result
    typedef logic [31:0]                  InstAddr;  // Program counter
    typedef logic [`RV_REG_ADDR_BITS-1:0] RegAddr;   // Register index

    // Major opcodes kept in this slice
    typedef enum logic [6:0]
    {
        OP     = 7'b0110011,  // Register-register ALU
        OP_IMM = 7'b0010011,  // Register-immediate ALU
        LUI    = 7'b0110111,  // Load upper immediate
        AUIPC  = 7'b0010111   // Add upper immediate to PC
    } Opcode;

    typedef enum logic [3:0]
    {
        ADD,     // A + B
        SUB,     // A - B
        SLL,     // Logical left shift
        SLT,     // Signed less than
        SLTU,    // Unsigned less than
        XOR,     // Bitwise xor
        SRL,     // Logical right shift
        SRA,     // Arithmetic right shift
        OR,      // Bitwise or
        AND,     // Bitwise and
        PASS_B   // B straight through
    } AluOp;

endpackage

// File: hdl/RvPipe.sv
package RvPipe;

    // Source of ALU operand A
    typedef enum logic [1:0]
    {
        OPA_REG,   // rs1 value
        OPA_PC,    // Instruction PC
        OPA_ZERO   // Constant zero
    } OperandASel;

    // Source of ALU operand B
    typedef enum logic
    {
        OPB_REG,   // rs2 value
        OPB_IMM    // Decoded immediate
    } OperandBSel;

    typedef struct packed
    {
        logic          isValid;      // Slot holds a live instruction
        logic          regWrEnable;  // Writes a nonzero rd
        RvIsa::RegAddr regWrAddr;    // Destination register
        RvIsa::AluOp   aluControl;   // ALU function
        OperandASel    operandASel;
        OperandBSel    operandBSel;
    } IdExCtrl;

    typedef struct packed
    {
        RvIsa::InstAddr pc;          // PC of the instruction
        RvIsa::Data     instIMM;     // Sign extended or upper immediate
        RvIsa::Data     dataA;       // rs1 value read at decode
        RvIsa::Data     dataB;       // rs2 value read at decode
        RvIsa::RegAddr  rs1Addr;     // Kept for forwarding compare
        RvIsa::RegAddr  rs2Addr;
    } IdExData;

    typedef struct packed
    {
        RvIsa::RegAddr  regAddr;     // Destination register
        RvIsa::Data     data;        // ALU result
        RvIsa::InstAddr pc;          // Producing instruction
    } ExResult;

endpackage

// File: hdl/InstDecoder.sv
`timescale 1ns/10ps

module InstDecoder
(
    input  RvIsa::Inst      i_inst,       // Instruction word
    input  RvIsa::InstAddr  i_pc,         // Its PC
    input  logic            i_instValid,  // Single cycle strobe
    output RvIsa::RegAddr   o_rs1Addr,    // To register file port A
    output RvIsa::RegAddr   o_rs2Addr,    // To register file port B
    input  RvIsa::Data      i_rs1Data,    // From register file port A
    input  RvIsa::Data      i_rs2Data,    // From register file port B
    output RvPipe::IdExCtrl o_ctrl,       // Control for ID/EX
    output RvPipe::IdExData o_data        // Operands for ID/EX
);

    RvIsa::Opcode       opcode;   // Major opcode
    logic [2:0]         funct3;
    logic [6:0]         funct7;
    RvIsa::RegAddr      rdAddr;
    RvIsa::Data         immI;     // I-type immediate
    RvIsa::Data         immU;     // U-type immediate
    logic               legal;    // Supported encoding
    logic               useRs1;
    logic               useRs2;
    RvIsa::AluOp        aluOp;
    RvPipe::OperandASel aSel;
    RvPipe::OperandBSel bSel;
    RvIsa::Data         imm;

    // Shared funct3 map for OP and OP_IMM
    function automatic RvIsa::AluOp aluFromFunct(input logic [2:0] f3, input logic alt);
        RvIsa::AluOp op;
        case (f3)
            3'b000:  op = alt ? RvIsa::SUB : RvIsa::ADD;
            3'b001:  op = RvIsa::SLL;
            3'b010:  op = RvIsa::SLT;
            3'b011:  op = RvIsa::SLTU;
            3'b100:  op = RvIsa::XOR;
            3'b101:  op = alt ? RvIsa::SRA : RvIsa::SRL;
            3'b110:  op = RvIsa::OR;
            default: op = RvIsa::AND;
        endcase
        return op;
    endfunction

    assign opcode = RvIsa::Opcode'(i_inst[6:0]);
    assign rdAddr = i_inst[11:7];
    assign funct3 = i_inst[14:12];
    assign funct7 = i_inst[31:25];
    assign immI   = {{20{i_inst[31]}}, i_inst[31:20]};  // Sign extended
    assign immU   = {i_inst[31:12], 12'b0};

    always_comb
    begin
        legal  = 1'b0;
        useRs1 = 1'b0;
        useRs2 = 1'b0;
        aluOp  = RvIsa::ADD;
        aSel   = RvPipe::OPA_REG;
        bSel   = RvPipe::OPB_REG;
        imm    = '0;
        case (opcode)
            RvIsa::OP:
            begin
                legal  = (funct7 == 7'b0000000) ||
                         ((funct7 == 7'b0100000) && ((funct3 == 3'b000) || (funct3 == 3'b101)));
                aluOp  = aluFromFunct(funct3, funct7[5]);  // Bit 5 picks SUB or SRA
                useRs1 = 1'b1;
                useRs2 = 1'b1;
            end
            RvIsa::OP_IMM:
            begin
                case (funct3)
                    3'b001:  legal = (funct7 == 7'b0000000);  // SLLI
                    3'b101:  legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
                    default: legal = 1'b1;                    // Plain immediate ops
                endcase
                aluOp  = aluFromFunct(funct3, (funct3 == 3'b101) && funct7[5]);
                imm    = immI;
                bSel   = RvPipe::OPB_IMM;
                useRs1 = 1'b1;
            end
            RvIsa::LUI:
            begin
                legal = 1'b1;
                aluOp = RvIsa::PASS_B;   // Result is the immediate
                aSel  = RvPipe::OPA_ZERO;
                bSel  = RvPipe::OPB_IMM;
                imm   = immU;
            end
            RvIsa::AUIPC:
            begin
                legal = 1'b1;
                aSel  = RvPipe::OPA_PC;  // PC plus upper immediate
                bSel  = RvPipe::OPB_IMM;
                imm   = immU;
            end
            default:
                legal = 1'b0;            // Unsupported opcode
        endcase
    end

    assign o_rs1Addr = useRs1 ? i_inst[19:15] : '0;  // Unused sources read x0
    assign o_rs2Addr = useRs2 ? i_inst[24:20] : '0;

    always_comb
    begin
        o_ctrl.isValid     = i_instValid && legal;
        o_ctrl.regWrEnable = legal && (rdAddr != '0);  // x0 writes make no result
        o_ctrl.regWrAddr   = rdAddr;
        o_ctrl.aluControl  = aluOp;
        o_ctrl.operandASel = aSel;
        o_ctrl.operandBSel = bSel;
        o_data.pc          = i_pc;
        o_data.instIMM     = imm;
        o_data.dataA       = i_rs1Data;
        o_data.dataB       = i_rs2Data;
        o_data.rs1Addr     = o_rs1Addr;
        o_data.rs2Addr     = o_rs2Addr;
    end

    // Every immediate form must take B from the immediate
    always_comb
    begin
        if (o_ctrl.isValid && (opcode != RvIsa::OP))
            assert (o_ctrl.operandBSel == RvPipe::OPB_IMM)
            else $error("Decoder selected register operand B for immediate form");
    end

endmodule

// File: hdl/RegisterFile.sv
`timescale 1ns/10ps
`include "rv_defines.svh"

module RegisterFile
(
    input  logic          i_clock,      // Clock
    input  logic          i_reset,      // Synchronous reset
    input  RvIsa::RegAddr i_rdAddrA,    // Read port A address
    input  RvIsa::RegAddr i_rdAddrB,    // Read port B address
    output RvIsa::Data    o_rdDataA,
    output RvIsa::Data    o_rdDataB,
    input  logic          i_wrEnable,   // Writeback strobe
    input  RvIsa::RegAddr i_wrAddr,
    input  RvIsa::Data    i_wrData
);

    RvIsa::Data regFile [`RV_REG_COUNT];  // Architectural state

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            for (int i = 0; i < `RV_REG_COUNT; i++)
                regFile[i] <= '0;
        end
        else if (i_wrEnable && (i_wrAddr != '0))  // x0 never written
        begin
            regFile[i_wrAddr] <= i_wrData;
        end
    end

    // x0 reads zero and a same cycle write is bypassed to the reader
    assign o_rdDataA = (i_rdAddrA == '0) ? '0 :
                       (i_wrEnable && (i_wrAddr == i_rdAddrA)) ? i_wrData : regFile[i_rdAddrA];
    assign o_rdDataB = (i_rdAddrB == '0) ? '0 :
                       (i_wrEnable && (i_wrAddr == i_rdAddrB)) ? i_wrData : regFile[i_rdAddrB];

    // x0 keeps its zero across every later cycle
    assert property (@(posedge i_clock) disable iff (i_reset)
        (regFile[0] == '0) |=> (regFile[0] == '0))
        else $error("Register x0 lost its zero value");

endmodule

// File: hdl/PipelineIDEX.sv
`timescale 1ns/10ps

module PipelineIDEX
(
    input  logic            i_clock,   // Clock
    input  logic            i_reset,   // Synchronous reset
    input  logic            i_stall,   // Hold current slot over flush
    input  logic            i_flush,   // Empty the slot
    input  RvPipe::IdExCtrl i_ctrl,    // Control from decode
    input  RvPipe::IdExData i_data,    // Operands from decode
    output RvPipe::IdExCtrl o_ctrl,    // Control to execute
    output RvPipe::IdExData o_data     // Operands to execute
);

    always_ff @(posedge i_clock)
    begin
        casez ({i_reset, i_stall, i_flush})
            3'b1??,                        // Reset
            3'b001:                        // Flush
                o_ctrl.isValid <= 1'b0;    // Payload left as is
            3'b01?:                        // Stall
                ;
            default:                       // Normal load
            begin
                o_ctrl <= i_ctrl;
                o_data <= i_data;
            end
        endcase
    end

    // A stalled slot presents the same control next cycle
    assert property (@(posedge i_clock) disable iff (i_reset)
        i_stall |=> $stable(o_ctrl))
        else $error("ID/EX control changed during stall");

endmodule

// File: hdl/ExecuteStage.sv
`timescale 1ns/10ps

module ExecuteStage
(
    input  logic            i_clock,        // Clock
    input  logic            i_reset,        // Synchronous reset
    input  logic            i_stall,        // Blocks result capture
    input  RvPipe::IdExCtrl i_ctrl,         // Registered control
    input  RvPipe::IdExData i_data,         // Registered operands
    output logic            o_resultValid,  // Result strobe and RF write enable
    output RvPipe::ExResult o_result        // Registered result
);

    logic       fwdValid;    // Result register usable for forwarding
    logic       fwdA;
    logic       fwdB;
    RvIsa::Data srcA;        // rs1 value after forwarding
    RvIsa::Data srcB;        // rs2 value after forwarding
    RvIsa::Data opA;
    RvIsa::Data opB;
    logic [4:0] shamt;
    RvIsa::Data aluOut;
    logic       loadResult;

    // Back-to-back dependency served from the result register
    assign fwdA = fwdValid && (o_result.regAddr != '0) && (o_result.regAddr == i_data.rs1Addr);
    assign fwdB = fwdValid && (o_result.regAddr != '0) && (o_result.regAddr == i_data.rs2Addr);
    assign srcA = fwdA ? o_result.data : i_data.dataA;
    assign srcB = fwdB ? o_result.data : i_data.dataB;

    always_comb
    begin
        case (i_ctrl.operandASel)
            RvPipe::OPA_PC:   opA = RvIsa::Data'(i_data.pc);
            RvPipe::OPA_ZERO: opA = '0;
            default:          opA = srcA;
        endcase
    end

    assign opB   = (i_ctrl.operandBSel == RvPipe::OPB_IMM) ? i_data.instIMM : srcB;
    assign shamt = opB[4:0];   // Low five bits only

    always_comb
    begin
        case (i_ctrl.aluControl)
            RvIsa::ADD:  aluOut = opA + opB;
            RvIsa::SUB:  aluOut = opA - opB;
            RvIsa::SLL:  aluOut = opA << shamt;
            RvIsa::SLT:  aluOut = RvIsa::Data'($signed(opA) < $signed(opB));
            RvIsa::SLTU: aluOut = RvIsa::Data'(opA < opB);
            RvIsa::XOR:  aluOut = opA ^ opB;
            RvIsa::SRL:  aluOut = opA >> shamt;
            RvIsa::SRA:  aluOut = RvIsa::Data'($signed(opA) >>> shamt);  // Sign fill
            RvIsa::OR:   aluOut = opA | opB;
            RvIsa::AND:  aluOut = opA & opB;
            default:     aluOut = opB;  // PASS_B
        endcase
    end

    assign loadResult = i_ctrl.isValid && i_ctrl.regWrEnable;

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            o_resultValid <= 1'b0;
            fwdValid      <= 1'b0;
            o_result      <= '0;
        end
        else if (!i_stall)
        begin
            o_resultValid <= loadResult;
            fwdValid      <= loadResult;
            if (loadResult)
            begin
                o_result.regAddr <= i_ctrl.regWrAddr;
                o_result.data    <= aluOut;
                o_result.pc      <= i_data.pc;
            end
        end
        else
        begin
            // Strobe drops but the value stays for the held consumer
            o_resultValid <= 1'b0;
        end
    end

    // A held instruction is announced once
    assert property (@(posedge i_clock) disable iff (i_reset)
        (o_resultValid && i_stall) |=> !(o_resultValid && (o_result.pc == $past(o_result.pc))))
        else $error("Result repeated during stall");

endmodule

// File: hdl/DecodeExecuteTop.sv
`timescale 1ns/10ps

module DecodeExecuteTop
(
    input  logic            i_clock,        // Clock
    input  logic            i_reset,        // Synchronous reset
    input  logic            i_instValid,    // Instruction strobe
    input  logic            i_stall,        // External stall
    input  logic            i_flush,        // External flush
    input  RvIsa::Inst      i_inst,         // Instruction word
    input  RvIsa::InstAddr  i_pc,           // Its PC
    output logic            o_resultValid,  // Result strobe
    output RvPipe::ExResult o_result        // Result payload
);

    RvIsa::RegAddr   rs1Addr;   // Decode source addresses
    RvIsa::RegAddr   rs2Addr;
    RvIsa::Data      rs1Data;   // Register file read data
    RvIsa::Data      rs2Data;
    RvPipe::IdExCtrl decCtrl;   // Decode side of ID/EX
    RvPipe::IdExData decData;
    RvPipe::IdExCtrl exCtrl;    // Execute side of ID/EX
    RvPipe::IdExData exData;

    InstDecoder decoder
    (
        .i_inst      (i_inst),
        .i_pc        (i_pc),
        .i_instValid (i_instValid),
        .o_rs1Addr   (rs1Addr),
        .o_rs2Addr   (rs2Addr),
        .i_rs1Data   (rs1Data),
        .i_rs2Data   (rs2Data),
        .o_ctrl      (decCtrl),
        .o_data      (decData)
    );

    RegisterFile regFile
    (
        .i_clock    (i_clock),
        .i_reset    (i_reset),
        .i_rdAddrA  (rs1Addr),
        .i_rdAddrB  (rs2Addr),
        .o_rdDataA  (rs1Data),
        .o_rdDataB  (rs2Data),
        .i_wrEnable (o_resultValid),     // Writeback on result strobe
        .i_wrAddr   (o_result.regAddr),
        .i_wrData   (o_result.data)
    );

    PipelineIDEX idEx
    (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .i_stall (i_stall),
        .i_flush (i_flush),
        .i_ctrl  (decCtrl),
        .i_data  (decData),
        .o_ctrl  (exCtrl),
        .o_data  (exData)
    );

    ExecuteStage execute
    (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_stall       (i_stall),
        .i_ctrl        (exCtrl),
        .i_data        (exData),
        .o_resultValid (o_resultValid),
        .o_result      (o_result)
    );

endmodule

// File: tests/RvSliceModel.sv
`include "rv_defines.svh"

package RvSliceModel;

    RvIsa::Data regs [`RV_REG_COUNT];  // Architectural registers in program order

    function automatic void clearRegs();
        for (int i = 0; i < `RV_REG_COUNT; i++)
            regs[i] = '0;
    endfunction

    // Integer result of one funct3 operation
    function automatic RvIsa::Data aluRef(input logic [2:0] f3, input logic alt,
                                          input RvIsa::Data a, input RvIsa::Data b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;  // Alt selects subtract
            3'd1:    return a << b[4:0];
            3'd2:    return RvIsa::Data'($signed(a) < $signed(b));
            3'd3:    return RvIsa::Data'(a < b);
            3'd4:    return a ^ b;
            3'd5:    return alt ? RvIsa::Data'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // Expected result of one accepted instruction, then commit to the registers
    function automatic logic predict(input RvIsa::Inst inst, input RvIsa::InstAddr pc,
                                     output RvPipe::ExResult res);
        RvIsa::RegAddr rd;
        RvIsa::Data    immI;
        logic [2:0]    f3;
        logic [6:0]    f7;
        logic          legal;
        rd    = inst[11:7];
        f3    = inst[14:12];
        f7    = inst[31:25];
        immI  = {{20{inst[31]}}, inst[31:20]};
        legal = 1'b1;
        res   = '0;
        case (inst[6:0])
            RvIsa::OP:
            begin
                legal    = (f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5)));
                res.data = aluRef(f3, f7[5], regs[inst[19:15]], regs[inst[24:20]]);
            end
            RvIsa::OP_IMM:
            begin
                if (f3 == 3'd1)
                    legal = (f7 == 7'h00);                     // SLLI has one form
                else if (f3 == 3'd5)
                    legal = (f7 == 7'h00) || (f7 == 7'h20);    // SRLI or SRAI
                res.data = aluRef(f3, (f3 == 3'd5) && f7[5], regs[inst[19:15]], immI);
            end
            RvIsa::LUI:   res.data = {inst[31:12], 12'b0};
            RvIsa::AUIPC: res.data = pc + {inst[31:12], 12'b0};
            default:      legal = 1'b0;
        endcase
        res.regAddr = rd;
        res.pc      = pc;
        if (legal && (rd != '0))
            regs[rd] = res.data;  // x0 stays zero
        return legal && (rd != '0);
    endfunction

    // Half the time reuse the hint
    function automatic RvIsa::RegAddr pickReg(input RvIsa::RegAddr hint);
        if ($urandom_range(0, 1) == 0)
            return hint;
        return RvIsa::RegAddr'($urandom());
    endfunction

    // Random mix of kept, shifted, upper and illegal encodings
    function automatic RvIsa::Inst randomInst(input RvIsa::RegAddr hint);
        RvIsa::RegAddr rd;
        RvIsa::RegAddr rs1;
        RvIsa::RegAddr rs2;
        logic [2:0]    f3;
        logic [6:0]    f7;
        logic [11:0]   imm;
        int unsigned   kind;
        rd   = ($urandom_range(0, 9) == 0) ? '0 : RvIsa::RegAddr'($urandom());  // Some x0 writes
        rs1  = pickReg(hint);
        rs2  = pickReg(hint);
        f3   = 3'($urandom());
        f7   = (((f3 == 3'd0) || (f3 == 3'd5)) && ($urandom_range(0, 1) == 1)) ? 7'h20 : 7'h00;
        imm  = 12'($urandom());
        kind = $urandom_range(0, 16);
        if (kind < 6)
            return {f7, rs2, rs1, f3, rd, RvIsa::OP};
        if (kind < 11)
        begin
            if ((f3 == 3'd1) || (f3 == 3'd5))
                imm = {f7, imm[4:0]};                          // Shift amount form
            return {imm, rs1, f3, rd, RvIsa::OP_IMM};
        end
        if (kind < 13)
            return {imm, rs1, f3, rd, RvIsa::LUI};
        if (kind == 13)
            return {imm, rs1, f3, rd, RvIsa::AUIPC};
        if (kind == 14)
            return {7'h01, rs2, rs1, f3, rd, RvIsa::OP};       // Multiply extension
        if (kind == 15)
            return {7'h20, rs2, rs1, 3'd1, rd, RvIsa::OP_IMM}; // SLLI with bad funct7
        return {imm, rs1, f3, rd, 7'b0000011};                 // Load opcode
    endfunction

endpackage

// File: tests/DecodeExecuteTb.sv
`timescale 1ns/10ps
`include "rv_defines.svh"

module DecodeExecuteTb;

    logic            clock;
    logic            reset;
    logic            instValid;
    logic            stall;
    logic            flush;
    RvIsa::Inst      inst;
    RvIsa::InstAddr  pc;
    logic            resultValid;
    RvPipe::ExResult result;

    RvPipe::ExResult expectQ[$];  // Accepted writers in program order
    int              dueQ[$];     // Cycle of arrival, -1 while held in ID/EX
    int              cycleCount;  // Rising edges so far
    logic            slotBusy;    // A writer sits in ID/EX
    RvIsa::InstAddr  nextPc;
    RvIsa::RegAddr   lastRd;      // Newest accepted destination
    RvIsa::RegAddr   olderRd;     // The one before it
    int              waitCycles;

    DecodeExecuteTop UUT
    (
        .i_clock       (clock),
        .i_reset       (reset),
        .i_instValid   (instValid),
        .i_stall       (stall),
        .i_flush       (flush),
        .i_inst        (inst),
        .i_pc          (pc),
        .o_resultValid (resultValid),
        .o_result      (result)
    );

    always #2 clock = ~clock;  // 4 ns period

    always @(posedge clock)
        cycleCount <= cycleCount + 1;

    task automatic failRun(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic compareData(input string name, input RvIsa::Data actual,
                               input RvIsa::Data expected);
        if (actual !== expected)
            failRun($sformatf("MISMATCH time=%0t signal=%s actual=%h expected=%h",
                              $time, name, actual, expected));
    endtask

    task automatic compareRegAddr(input string name, input RvIsa::RegAddr actual,
                                  input RvIsa::RegAddr expected);
        if (actual !== expected)
            failRun($sformatf("MISMATCH time=%0t signal=%s actual=%0d expected=%0d",
                              $time, name, actual, expected));
    endtask

    task automatic comparePc(input string name, input RvIsa::InstAddr actual,
                             input RvIsa::InstAddr expected);
        if (actual !== expected)
            failRun($sformatf("MISMATCH time=%0t signal=%s actual=%h expected=%h",
                              $time, name, actual, expected));
    endtask

    task automatic compareResult(input RvPipe::ExResult actual, input RvPipe::ExResult expected);
        comparePc("o_result.pc", actual.pc, expected.pc);  // Catches lost or reordered work
        compareRegAddr("o_result.regAddr", actual.regAddr, expected.regAddr);
        compareData("o_result.data", actual.data, expected.data);
    endtask

    // Outputs after the last rising edge
    task automatic checkOutputs();
        RvPipe::ExResult expected;
        int              due;
        if (resultValid === 1'b1)
        begin
            if (expectQ.size() == 0)
                failRun($sformatf("Result strobe in cycle %0d with nothing accepted", cycleCount));
            else
            begin
                expected = expectQ.pop_front();
                due      = dueQ.pop_front();
                compareResult(result, expected);
                if (due != cycleCount)
                    failRun($sformatf("Result for pc %h came in cycle %0d instead of %0d",
                                      expected.pc, cycleCount, due));
            end
        end
        else if (resultValid !== 1'b0)
            failRun("Result strobe is unknown");
        else if ((dueQ.size() != 0) && (dueQ[0] == cycleCount))
            failRun($sformatf("Result for pc %h missing in cycle %0d", expectQ[0].pc, cycleCount));
    endtask

    // Check the last edge before driving inputs for the next one
    task automatic stepCycle(input logic doStrobe, input RvIsa::Inst word,
                             input logic doStall, input logic doFlush);
        RvPipe::ExResult expected;
        @(negedge clock);
        checkOutputs();
        instValid = doStrobe;
        inst      = word;
        pc        = nextPc;
        stall     = doStall;
        flush     = doFlush;
        if (slotBusy && !doStall)
        begin
            dueQ[dueQ.size() - 1] = cycleCount + 1;  // Executes at the coming edge
            slotBusy = 1'b0;
        end
        if (doStrobe && !doStall && !doFlush)        // Stall or flush drops the offer
        begin
            if (RvSliceModel::predict(word, nextPc, expected))
            begin
                expectQ.push_back(expected);
                dueQ.push_back(-1);
                slotBusy = 1'b1;
            end
            olderRd = lastRd;
            lastRd  = word[11:7];
        end
        if (doStrobe)
            nextPc = nextPc + 4;
    endtask

    function automatic RvIsa::RegAddr mixedHint();
        return ($urandom_range(0, 1) == 0) ? lastRd : olderRd;
    endfunction

    initial
    begin
        clock      = 1'b0;
        reset      = 1'b1;
        instValid  = 1'b0;
        stall      = 1'b0;
        flush      = 1'b0;
        inst       = `RV_NOP_INST;
        pc         = '0;
        cycleCount = 0;
        slotBusy   = 1'b0;
        nextPc     = 32'h0000_1000;
        lastRd     = '0;
        olderRd    = '0;
        void'($urandom(86));
        RvSliceModel::clearRegs();
        repeat (4) @(negedge clock);  // Four reset edges
        reset = 1'b0;
        repeat (6) stepCycle(1'b0, `RV_NOP_INST, 1'b0, 1'b0);  // Quiet after reset
        for (int i = 0; i < 300; i++)  // Free mix with exact latency
            stepCycle($urandom_range(0, 3) != 0, RvSliceModel::randomInst(mixedHint()),
                      1'b0, 1'b0);
        for (int i = 0; i < 120; i++)  // Back-to-back chains through forwarding
            stepCycle(1'b1, RvSliceModel::randomInst(lastRd), 1'b0, 1'b0);
        for (int i = 0; i < 120; i++)  // Distance two through write-through
            stepCycle(1'b1, RvSliceModel::randomInst(olderRd), 1'b0, 1'b0);
        for (int i = 0; i < 500; i++)  // Stall and flush pulses that sometimes overlap
            stepCycle($urandom_range(0, 3) != 0, RvSliceModel::randomInst(mixedHint()),
                      $urandom_range(0, 3) == 0, $urandom_range(0, 6) == 0);
        waitCycles = 0;
        while ((expectQ.size() != 0) && (waitCycles < 20))
        begin
            stepCycle(1'b0, `RV_NOP_INST, 1'b0, 1'b0);
            waitCycles++;
        end
        if (expectQ.size() != 0)
            failRun($sformatf("Timed out waiting for %0d outstanding results", expectQ.size()));
        else
        begin
            repeat (6) stepCycle(1'b0, `RV_NOP_INST, 1'b0, 1'b0);  // No stray strobe
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

// File: rvIdExSlice.f
+incdir+include
hdl/RvIsa.sv
hdl/RvPipe.sv
hdl/InstDecoder.sv
hdl/RegisterFile.sv
hdl/PipelineIDEX.sv
hdl/ExecuteStage.sv
hdl/DecodeExecuteTop.sv
tests/RvSliceModel.sv
tests/DecodeExecuteTb.sv

// File: build.sh
#!/bin/sh
# Verilator build of the decode/execute slice and one run of its testbench
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/10ps -j 0 \
    -f rvIdExSlice.f --top-module DecodeExecuteTb -o simDecodeExecute || exit 1
simOutput="$(./obj_dir/simDecodeExecute 2>&1)"
echo "$simOutput"
echo "$simOutput" | grep -qx "STATUS: PASS" && exit 0 || exit 1
